// ==== include/gfx_map_cfg.svh ====
/* widths and bank count for the graphics ROM address mapper
   included by the package and every stage that sizes a port */
`ifndef GFX_MAP_CFG_SVH
`define GFX_MAP_CFG_SVH

// tile code from the layer fetch unit
`define GFX_CODE_W 16

// tile row inside the code, lowest address bits
`define GFX_ROW_W 4

// ROM word address out to the memory side
`define GFX_ROM_AW 20

`define GFX_BANKS 4     // one chip select each

`define GFX_MISS_W 8    // saturating unmapped access count

`endif

// ==== verilog/gfx_map_pkg.sv ====
/* shared types of the graphics ROM mapper pipeline
   referenced by scoped name from each stage and the top level */
`include "gfx_map_cfg.svh"

package gfx_map_pkg;

    // layer number carried with each fetch request
    typedef enum logic [2:0] {
        layer_obj  = 3'd0,  // objects
        layer_scr1 = 3'd1,
        layer_scr2 = 3'd2,
        layer_scr3 = 3'd3,
        layer_star = 3'd4   // 5 to 7 unused
    } layer_e;

    // board bank decode type, static per game
    typedef enum logic [1:0] {
        map_flat  = 2'd0,   // everything but stars in bank 0
        map_split = 2'd1,
        map_quad  = 2'd2,
        map_range = 2'd3
    } mapper_e;

    // request from the layer fetch unit
    typedef struct packed {
        layer_e                  layer;
        logic [`GFX_CODE_W-1:0]  code;
        logic [`GFX_ROW_W-1:0]   row;
    } gfx_req_t;

    // one-hot bank select, all zero when unmapped
    typedef logic [`GFX_BANKS-1:0] bank_sel_t;

    // decode to execute payload
    typedef struct packed {
        gfx_req_t   req;
        bank_sel_t  bank;
    } gfx_dec_t;

    // execute to result payload
    typedef struct packed {
        logic [`GFX_ROM_AW-1:0]  addr;
        bank_sel_t               cs;
    } gfx_addr_t;

endpackage

// ==== verilog/gfx_bank_decode.sv ====
/* first mapper stage, finds the ROM bank of a tile fetch
   from the board mapper type, the layer and the top code bits */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_bank_decode (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  gfx_map_pkg::gfx_req_t  req_data,
    input  gfx_map_pkg::mapper_e   mapper,
    output logic                   dec_valid,
    output gfx_map_pkg::gfx_dec_t  dec
);

    localparam gfx_map_pkg::bank_sel_t bank_none = '0;
    localparam gfx_map_pkg::bank_sel_t bank_0    = gfx_map_pkg::bank_sel_t'(1);
    localparam gfx_map_pkg::bank_sel_t bank_1    = gfx_map_pkg::bank_sel_t'(2);
    localparam gfx_map_pkg::bank_sel_t bank_2    = gfx_map_pkg::bank_sel_t'(4);
    localparam gfx_map_pkg::bank_sel_t bank_3    = gfx_map_pkg::bank_sel_t'(8);

    logic [2:0]              top;        // code bits 15 to 13
    logic                    code_hi;    // code bit 15
    logic                    star_low;   // code bits 15 and 14 clear
    gfx_map_pkg::bank_sel_t  bank_nxt;

    assign top      = req_data.code[`GFX_CODE_W-1 -: 3];
    assign code_hi  = req_data.code[`GFX_CODE_W-1];
    assign star_low = req_data.code[`GFX_CODE_W-1 -: 2] == 2'b00;

    // stands in for the per-game PAL equations
    always_comb begin
        bank_nxt = bank_none;
        case (mapper)
            gfx_map_pkg::map_flat: begin
                case (req_data.layer)
                    gfx_map_pkg::layer_obj,
                    gfx_map_pkg::layer_scr1,
                    gfx_map_pkg::layer_scr2,
                    gfx_map_pkg::layer_scr3: bank_nxt = bank_0;
                    default:                 bank_nxt = bank_none; // stars too
                endcase
            end
            gfx_map_pkg::map_split: begin
                case (req_data.layer)
                    gfx_map_pkg::layer_obj:  bank_nxt = code_hi ? bank_1 : bank_0;
                    gfx_map_pkg::layer_scr1,
                    gfx_map_pkg::layer_scr2,
                    gfx_map_pkg::layer_scr3: bank_nxt = bank_1;
                    gfx_map_pkg::layer_star: bank_nxt = bank_2;
                    default:                 bank_nxt = bank_none;
                endcase
            end
            gfx_map_pkg::map_quad: begin
                case (req_data.layer)
                    gfx_map_pkg::layer_obj,
                    gfx_map_pkg::layer_scr1,
                    gfx_map_pkg::layer_scr2,
                    gfx_map_pkg::layer_scr3: begin
                        // bank number equals layer number
                        bank_nxt = bank_0 << req_data.layer[1:0];
                    end
                    gfx_map_pkg::layer_star: bank_nxt = star_low ? bank_3 : bank_none;
                    default:                 bank_nxt = bank_none;
                endcase
            end
            gfx_map_pkg::map_range: begin
                case (req_data.layer)
                    gfx_map_pkg::layer_obj: begin
                        if (top < 3'd3) begin
                            bank_nxt = bank_0;
                        end else if (top <= 3'd5) begin
                            bank_nxt = bank_1;
                        end else begin
                            bank_nxt = bank_none;   // top 6 and 7 left open
                        end
                    end
                    gfx_map_pkg::layer_scr1: bank_nxt = bank_2;
                    gfx_map_pkg::layer_scr2,
                    gfx_map_pkg::layer_scr3: bank_nxt = bank_3;
                    default:                 bank_nxt = bank_none;
                endcase
            end
            default: bank_nxt = bank_none;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= req;
        end
    end

    // payload only moves with a request
    always_ff @(posedge clk) begin
        if (req) begin
            dec.req  <= req_data;
            dec.bank <= bank_nxt;
        end
    end

endmodule

// ==== verilog/gfx_bank_apply.sv ====
/* second mapper stage, applies the bank offset and mask
   to the top code nibble and forms the ROM word address */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_bank_apply (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      dec_valid,
    input  gfx_map_pkg::gfx_dec_t     dec,
    input  logic [4*`GFX_BANKS-1:0]   bank_offset,
    input  logic [4*`GFX_BANKS-1:0]   bank_mask,
    output logic                      app_valid,
    output gfx_map_pkg::gfx_addr_t    app
);

    logic [3:0]              offset;
    logic [3:0]              mask;
    logic [3:0]              nib;       // remapped code nibble
    logic [`GFX_ROM_AW-1:0]  addr_nxt;

    // nibble n of each config word belongs to bank n
    always_comb begin
        offset = 4'h0;
        mask   = 4'hf;     // unmapped passes the code through
        for (int n = 0; n < `GFX_BANKS; n++) begin
            if (dec.bank == gfx_map_pkg::bank_sel_t'(1 << n)) begin
                offset = bank_offset[4*n +: 4];
                mask   = bank_mask[4*n +: 4];
            end
        end
    end

    assign nib      = (dec.req.code[`GFX_CODE_W-1 -: 4] & mask) | offset;
    assign addr_nxt = {nib, dec.req.code[`GFX_CODE_W-5:0], dec.req.row};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            app_valid <= 1'b0;
        end else begin
            app_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            app.addr <= addr_nxt;
            app.cs   <= dec.bank;   // chip select follows the bank
        end
    end

endmodule

// ==== verilog/gfx_map_result.sv ====
/* last mapper stage, drives the ROM address, chip selects and miss flag
   and keeps a saturating count of unmapped fetches for the host */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_map_result (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      app_valid,
    input  gfx_map_pkg::gfx_addr_t    app,
    output logic                      rom_ok,
    output logic                      rom_miss,
    output logic [`GFX_ROM_AW-1:0]    rom_addr,
    output gfx_map_pkg::bank_sel_t    rom_cs,
    output logic [`GFX_MISS_W-1:0]    miss_count
);

    logic miss_nxt;

    assign miss_nxt = app.cs == '0;   // no bank hit

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_ok   <= 1'b0;
            rom_miss <= 1'b0;
            rom_cs   <= '0;
        end else begin
            rom_ok <= app_valid;
            if (app_valid) begin
                rom_miss <= miss_nxt;
                rom_cs   <= app.cs;  // all zero on a miss, every ROM off
            end
        end
    end

    always_ff @(posedge clk) begin
        if (app_valid) begin
            rom_addr <= app.addr;
        end
    end

    // stops at all ones
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            miss_count <= '0;
        end else if (rom_ok && rom_miss && miss_count != '1) begin
            miss_count <= miss_count + 1'b1;
        end
    end

endmodule

// ==== verilog/gfx_map_top.sv ====
/* graphics ROM address mapper, layer fetch request in and ROM address out
   three registered stages so a result appears 3 cycles after each req */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_map_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      req,
    input  gfx_map_pkg::gfx_req_t     req_data,
    input  gfx_map_pkg::mapper_e      mapper,
    input  logic [4*`GFX_BANKS-1:0]   bank_offset,
    input  logic [4*`GFX_BANKS-1:0]   bank_mask,
    output logic                      rom_ok,
    output logic [`GFX_ROM_AW-1:0]    rom_addr,
    output gfx_map_pkg::bank_sel_t    rom_cs,
    output logic                      rom_miss,
    output logic [`GFX_MISS_W-1:0]    miss_count
);

    logic                    dec_valid;
    gfx_map_pkg::gfx_dec_t   dec;
    logic                    app_valid;
    gfx_map_pkg::gfx_addr_t  app;

    gfx_bank_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_data  (req_data),
        .mapper    (mapper),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    gfx_bank_apply u_apply (
        .clk         (clk),
        .rst         (rst),
        .dec_valid   (dec_valid),
        .dec         (dec),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .app_valid   (app_valid),
        .app         (app)
    );

    gfx_map_result u_result (
        .clk        (clk),
        .rst        (rst),
        .app_valid  (app_valid),
        .app        (app),
        .rom_ok     (rom_ok),
        .rom_miss   (rom_miss),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .miss_count (miss_count)
    );

endmodule

// ==== bench/gfx_map_assertions.sv ====
/* concurrent checks on the mapper outputs
   bound into gfx_map_top, watching latency, chip selects and the miss count */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_map_assertions (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  logic                    rom_ok,
    input  logic                    rom_miss,
    input  logic [`GFX_BANKS-1:0]   rom_cs,
    input  logic [`GFX_MISS_W-1:0]  miss_count
);

    // at most one ROM enabled
    cs_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(rom_cs))
        else $error("rom_cs has more than one chip select active");

    // three register stages between req and rom_ok
    ok_after_req: assert property (@(posedge clk) disable iff (rst) $past(req, 3) |-> rom_ok)
        else $error("rom_ok missing 3 cycles after req");

    ok_from_req: assert property (@(posedge clk) disable iff (rst) rom_ok |-> $past(req, 3))
        else $error("rom_ok without a req 3 cycles earlier");

    miss_no_cs: assert property (@(posedge clk) disable iff (rst) rom_miss |-> rom_cs == '0)
        else $error("rom_cs active on a miss");

    count_up: assert property (@(posedge clk) disable iff (rst)
        miss_count >= $past(miss_count))
        else $error("miss_count went down");

endmodule

bind gfx_map_top gfx_map_assertions u_assertions (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .rom_ok     (rom_ok),
    .rom_miss   (rom_miss),
    .rom_cs     (rom_cs),
    .miss_count (miss_count)
);

// ==== bench/gfx_map_tb.sv ====
/* testbench for the graphics ROM address mapper
   covers reset, decode table, offset and mask, pipelining and the miss counter */
`timescale 1ns/1ps
`include "gfx_map_cfg.svh"

module gfx_map_tb;

    typedef struct packed {
        logic [`GFX_ROM_AW-1:0]  addr;
        gfx_map_pkg::bank_sel_t  cs;
        logic                    miss;
        logic [31:0]             cycle;   // cycle the req was driven in
    } exp_t;

    logic                      clk;
    logic                      rst;
    logic                      req;
    gfx_map_pkg::gfx_req_t     req_data;
    gfx_map_pkg::mapper_e      mapper;
    logic [4*`GFX_BANKS-1:0]   bank_offset;
    logic [4*`GFX_BANKS-1:0]   bank_mask;
    logic                      rom_ok;
    logic [`GFX_ROM_AW-1:0]    rom_addr;
    gfx_map_pkg::bank_sel_t    rom_cs;
    logic                      rom_miss;
    logic [`GFX_MISS_W-1:0]    miss_count;

    exp_t                    exp_q[$];
    logic [31:0]             cycle;
    logic [31:0]             rng;
    logic [`GFX_MISS_W-1:0]  miss_model;   // expected miss_count
    int                      errors;
    int                      checks;
    string                   test_name;

    gfx_map_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .req         (req),
        .req_data    (req_data),
        .mapper      (mapper),
        .bank_offset (bank_offset),
        .bank_mask   (bank_mask),
        .rom_ok      (rom_ok),
        .rom_addr    (rom_addr),
        .rom_cs      (rom_cs),
        .rom_miss    (rom_miss),
        .miss_count  (miss_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // expected mapper output for one request
    function automatic exp_t ref_map(input gfx_map_pkg::gfx_req_t r,
                                     input gfx_map_pkg::mapper_e m,
                                     input logic [15:0] off_w,
                                     input logic [15:0] mask_w);
        exp_t        e;
        int          bank;    // -1 when unmapped
        int          lay;
        logic [2:0]  top;
        logic [3:0]  off;
        logic [3:0]  msk;
        e    = '0;
        bank = -1;
        lay  = int'(r.layer);
        top  = r.code[15:13];
        if (lay <= 4) begin
            case (m)
                gfx_map_pkg::map_flat: begin
                    if (lay <= 3) bank = 0;
                end
                gfx_map_pkg::map_split: begin
                    if (lay == 0) bank = int'(r.code[15]);
                    else if (lay <= 3) bank = 1;
                    else bank = 2;
                end
                gfx_map_pkg::map_quad: begin
                    if (lay <= 3) bank = lay;
                    else if (r.code[15:14] == 2'b00) bank = 3;
                end
                default: begin   // range mapper
                    if (lay == 0) begin
                        if (top < 3) bank = 0;
                        else if (top <= 5) bank = 1;
                    end else if (lay == 1) begin
                        bank = 2;
                    end else if (lay <= 3) begin
                        bank = 3;
                    end
                end
            endcase
        end
        off = 4'h0;
        msk = 4'hf;
        if (bank >= 0) begin
            off  = off_w[bank*4 +: 4];
            msk  = mask_w[bank*4 +: 4];
            e.cs = 4'b0001 << bank;
        end
        e.miss = bank < 0;
        e.addr = {(r.code[15:12] & msk) | off, r.code[11:0], r.row};
        return e;
    endfunction

    // results come back in request order, sampled mid cycle
    always @(negedge clk) begin
        exp_t e;
        if (!rst && rom_ok) begin
            if (exp_q.size() == 0) begin
                $display("rom_ok came with no request outstanding in %s", test_name);
                errors++;
            end else begin
                e = exp_q.pop_front();
                checks++;
                if (cycle - e.cycle != 32'd3) begin
                    $display("FAILED %s latency expected 3 actual %0d", test_name,
                             cycle - e.cycle);
                    errors++;
                end
                if (rom_addr !== e.addr) begin
                    $display("FAILED %s rom_addr expected %h actual %h", test_name,
                             e.addr, rom_addr);
                    errors++;
                end
                if (rom_cs !== e.cs) begin
                    $display("FAILED %s rom_cs expected %b actual %b", test_name, e.cs, rom_cs);
                    errors++;
                end
                if (rom_miss !== e.miss) begin
                    $display("FAILED %s rom_miss expected %b actual %b", test_name,
                             e.miss, rom_miss);
                    errors++;
                end
                if (e.miss && miss_model != '1) miss_model = miss_model + 1'b1;
            end
        end
    end

    // one request, leaves the bench one edge later
    task automatic send(input logic [2:0] lay, input logic [15:0] code, input logic [3:0] row);
        gfx_map_pkg::gfx_req_t r;
        exp_t                  e;
        r.layer  = gfx_map_pkg::layer_e'(lay);
        r.code   = code;
        r.row    = row;
        e        = ref_map(r, mapper, bank_offset, bank_mask);
        e.cycle  = cycle;
        exp_q.push_back(e);
        req      = 1'b1;
        req_data = r;
        @(posedge clk);
        #1;
        req = 1'b0;
    endtask

    // wait for all results, then compare the miss count
    task automatic drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout in %s, %0d results never returned", test_name, exp_q.size());
            errors++;
            exp_q.delete();
        end
        repeat (2) @(posedge clk);
        #1;
        checks++;
        if (miss_count !== miss_model) begin
            $display("FAILED %s miss_count expected %0d actual %0d", test_name,
                     miss_model, miss_count);
            errors++;
        end
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        req = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        rst        = 1'b0;
        miss_model = '0;
        checks++;
        if (rom_ok !== 1'b0 || rom_miss !== 1'b0 || rom_cs !== '0 || miss_count !== '0) begin
            $display("outputs not cleared by reset in %s", test_name);
            errors++;
        end
    endtask

    initial begin
        rst         = 1'b1;
        req         = 1'b0;
        req_data    = '0;
        mapper      = gfx_map_pkg::map_flat;
        bank_offset = '0;
        bank_mask   = '1;
        cycle       = '0;
        rng         = 32'h7fbd;
        miss_model  = '0;
        errors      = 0;
        checks      = 0;

        test_name = "reset";
        apply_reset();

        // every mapper, layer and top code value, both ends of each range
        test_name = "decode";
        for (int m = 0; m < 4; m++) begin
            mapper = gfx_map_pkg::mapper_e'(m);
            for (int lay = 0; lay < 8; lay++) begin
                for (int t = 0; t < 8; t++) begin
                    send(3'(lay), {3'(t), 13'h0000}, 4'h0);
                    send(3'(lay), {3'(t), 13'h1fff}, 4'hf);
                end
            end
            drain();
        end

        test_name = "offset_mask";
        for (int rnd = 0; rnd < 12; rnd++) begin
            mapper      = gfx_map_pkg::mapper_e'(rnd % 4);
            rng         = xorshift(rng);
            bank_offset = rng[15:0];
            bank_mask   = rng[31:16];
            for (int lay = 0; lay < 8; lay++) begin
                for (int k = 0; k < 4; k++) begin
                    rng = xorshift(rng);
                    send(3'(lay), rng[15:0], rng[19:16]);
                end
            end
            drain();
        end

        test_name = "back_to_back";
        for (int blk = 0; blk < 4; blk++) begin
            rng         = xorshift(rng);
            mapper      = gfx_map_pkg::mapper_e'(rng[1:0]);
            bank_offset = rng[23:8];
            rng         = xorshift(rng);
            bank_mask   = rng[15:0];
            for (int i = 0; i < 50; i++) begin
                rng = xorshift(rng);
                send(rng[22:20], rng[15:0], rng[19:16]);
            end
            drain();
        end

        // count from zero, then run into saturation
        test_name = "miss_count";
        apply_reset();
        mapper = gfx_map_pkg::map_flat;
        for (int i = 0; i < 150; i++) begin
            rng = xorshift(rng);
            send((i % 3 == 0) ? 3'd0 : 3'd4, rng[15:0], rng[19:16]);
        end
        drain();
        for (int i = 0; i < 200; i++) begin
            rng = xorshift(rng);
            send(3'd4, rng[15:0], rng[19:16]);
        end
        drain();
        checks++;
        if (miss_count !== 8'hff) begin
            $display("FAILED %s saturation expected ff actual %h", test_name, miss_count);
            errors++;
        end

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/gfx_map_pkg.sv
verilog/gfx_bank_decode.sv
verilog/gfx_bank_apply.sv
verilog/gfx_map_result.sv
verilog/gfx_map_top.sv
bench/gfx_map_assertions.sv
bench/gfx_map_tb.sv

// ==== Makefile ====
# Verilator build and run of the graphics ROM mapper testbench

TOP = gfx_map_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir
